// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_cpu
FILELIST  ?= mips_cpu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TB PASSED

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: mips_cpu.f
rtl/mips_pkg.sv
rtl/decoded_if.sv
rtl/mips_regfile.sv
rtl/mips_exec_unit.sv
rtl/mips_branch_unit.sv
rtl/mips_sequencer.sv
rtl/mips_cpu.sv
verif/tb_clock_gen.sv
verif/mips_cpu_sva.sv
verif/tb_mips_cpu.sv

// File: rtl/decoded_if.sv
`timescale 1ns/1ns

interface decoded_if;

    // decoded instruction and its operands, driven by the sequencer
    mips_pkg::opcode_e                   op;
    logic [mips_pkg::WORD_W-1:0]         rs_val;
    logic [mips_pkg::WORD_W-1:0]         rt_val;
    logic [mips_pkg::WORD_W-1:0]         imm_sext;
    logic [mips_pkg::WORD_W-1:0]         pc_next_seq;
    logic [mips_pkg::REG_ADDR_W-1:0]     dest;

    // results from the execute unit
    logic [mips_pkg::WORD_W-1:0]         alu_result;
    logic                                alu_we;

    // results from the branch unit
    logic                                taken;
    logic [mips_pkg::WORD_W-1:0]         target;
    logic                                halt_req;

    modport sequencer (
        output op, rs_val, rt_val, imm_sext, pc_next_seq, dest,
        input  alu_result, alu_we, taken, target, halt_req
    );

    modport exec (
        input  op, rs_val, rt_val, imm_sext, dest,
        output alu_result, alu_we
    );

    modport branch (
        input  op, rs_val, rt_val, imm_sext, pc_next_seq,
        output taken, target, halt_req
    );

endinterface

// File: rtl/mips_branch_unit.sv
`timescale 1ns/1ns

module mips_branch_unit (
    decoded_if.branch dec
);

    logic [mips_pkg::WORD_W-1:0] branch_offset;
    logic                        rs_negative;

    // the word offset is relative to the delay slot address
    assign branch_offset = {dec.imm_sext[mips_pkg::WORD_W-3:0], 2'b00};
    assign rs_negative   = dec.rs_val[mips_pkg::WORD_W-1];

    always_comb begin
        dec.taken  = 1'b0;
        dec.target = dec.pc_next_seq + branch_offset;
        case (dec.op)
            mips_pkg::OP_BEQ: begin
                dec.taken = (dec.rs_val == dec.rt_val);
            end
            mips_pkg::OP_BNE: begin
                dec.taken = (dec.rs_val != dec.rt_val);
            end
            mips_pkg::OP_BLTZ: begin
                dec.taken = rs_negative;
            end
            mips_pkg::OP_BGEZ: begin
                // zero counts as taken for BGEZ
                dec.taken = !rs_negative;
            end
            mips_pkg::OP_JR: begin
                dec.taken  = 1'b1;
                dec.target = dec.rs_val;
            end
            default: begin
                dec.taken = 1'b0;
            end
        endcase
    end

    // the sequencer only halts once the delay slot has also executed
    assign dec.halt_req = (dec.op == mips_pkg::OP_JR) && (dec.rs_val == mips_pkg::HALT_ADDR);

endmodule

// File: rtl/mips_cpu.sv
`timescale 1ns/1ns

module mips_cpu #(
    parameter logic [31:0] RESET_VECTOR = 32'd4
) (
    input  logic                          clk,
    input  logic                          reset,
    output logic                          active,
    output logic [mips_pkg::WORD_W-1:0]   register_v0,
    output logic [mips_pkg::WORD_W-1:0]   address,
    output logic                          read,
    input  logic                          waitrequest,
    input  logic [mips_pkg::WORD_W-1:0]   readdata
);

    logic [mips_pkg::REG_ADDR_W-1:0] rs_addr;
    logic [mips_pkg::REG_ADDR_W-1:0] rt_addr;
    logic [mips_pkg::WORD_W-1:0]     rs_data;
    logic [mips_pkg::WORD_W-1:0]     rt_data;
    logic                            wr_en;
    logic [mips_pkg::REG_ADDR_W-1:0] wr_addr;
    logic [mips_pkg::WORD_W-1:0]     wr_data;

    // one decoded instruction shared by the sequencer and both units
    decoded_if dec_bus ();

    mips_sequencer #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_seq (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .address     (address),
        .read        (read),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .dec         (dec_bus.sequencer),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    mips_exec_unit u_exec (
        .dec (dec_bus.exec)
    );

    mips_branch_unit u_branch (
        .dec (dec_bus.branch)
    );

    mips_regfile u_regs (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .v0      (register_v0)
    );

endmodule

// File: rtl/mips_exec_unit.sv
`timescale 1ns/1ns

module mips_exec_unit (
    decoded_if.exec dec
);

    localparam int unsigned EXT_W = mips_pkg::WORD_W - mips_pkg::IMM_W;

    logic [mips_pkg::WORD_W-1:0] imm_zext;
    logic                        is_alu_op;

    // ORI takes the immediate zero extended, ADDIU uses the sign extended form
    assign imm_zext = {{EXT_W{1'b0}}, dec.imm_sext[mips_pkg::IMM_W-1:0]};

    always_comb begin
        is_alu_op      = 1'b1;
        dec.alu_result = '0;
        case (dec.op)
            mips_pkg::OP_ADDIU: begin
                // no overflow trap, ADDIU wraps
                dec.alu_result = dec.rs_val + dec.imm_sext;
            end
            mips_pkg::OP_ORI: begin
                dec.alu_result = dec.rs_val | imm_zext;
            end
            mips_pkg::OP_ADDU: begin
                dec.alu_result = dec.rs_val + dec.rt_val;
            end
            mips_pkg::OP_SUBU: begin
                dec.alu_result = dec.rs_val - dec.rt_val;
            end
            mips_pkg::OP_AND: begin
                dec.alu_result = dec.rs_val & dec.rt_val;
            end
            mips_pkg::OP_OR: begin
                dec.alu_result = dec.rs_val | dec.rt_val;
            end
            default: begin
                // branches, JR and no-ops do not write a register
                is_alu_op = 1'b0;
            end
        endcase
    end

    // a write to $0 is suppressed here as well as in the register file
    assign dec.alu_we = is_alu_op && (dec.dest != '0);

endmodule

// File: rtl/mips_pkg.sv
package mips_pkg;

    // datapath and bus width in bits
    localparam int unsigned WORD_W = 32;

    // register index width for 32 general purpose registers
    localparam int unsigned REG_ADDR_W = 5;

    // width of the immediate field in I-type instructions
    localparam int unsigned IMM_W = 16;

    // $v0 is published at the top level
    localparam logic [REG_ADDR_W-1:0] V0_INDEX = 5'd2;

    // a JR to this address ends the program once its delay slot has run
    localparam logic [WORD_W-1:0] HALT_ADDR = 32'h0000_0000;

    // decoded operations where anything not listed decodes to OP_NOP
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADDIU,
        OP_ORI,
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_BEQ,
        OP_BNE,
        OP_BLTZ,
        OP_BGEZ,
        OP_JR
    } opcode_e;

    // sequencer states
    // ST_FETCH holds the Avalon read until waitrequest drops and
    // ST_EXEC lasts exactly one cycle per instruction
    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_HALT
    } seq_state_e;

endpackage

// File: rtl/mips_regfile.sv
`timescale 1ns/1ns

module mips_regfile (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   rs_addr,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   rt_addr,
    output logic [mips_pkg::WORD_W-1:0]       rs_data,
    output logic [mips_pkg::WORD_W-1:0]       rt_data,
    input  logic                              wr_en,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   wr_addr,
    input  logic [mips_pkg::WORD_W-1:0]       wr_data,
    output logic [mips_pkg::WORD_W-1:0]       v0
);

    localparam int unsigned NUM_REGS = 2 ** mips_pkg::REG_ADDR_W;

    logic [mips_pkg::WORD_W-1:0] regs [NUM_REGS];

    // every entry starts at zero after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            // $0 is never written and so stays zero
            regs[wr_addr] <= wr_data;
        end
    end

    // reads are combinational and the sequencer samples them inside ST_EXEC
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    assign v0 = regs[mips_pkg::V0_INDEX];

endmodule

// File: rtl/mips_sequencer.sv
`timescale 1ns/1ns

module mips_sequencer #(
    parameter logic [31:0] RESET_VECTOR = 32'd4
) (
    input  logic                              clk,
    input  logic                              reset,
    output logic                              active,
    output logic [mips_pkg::WORD_W-1:0]       address,
    output logic                              read,
    input  logic                              waitrequest,
    input  logic [mips_pkg::WORD_W-1:0]       readdata,
    decoded_if.sequencer                      dec,
    output logic [mips_pkg::REG_ADDR_W-1:0]   rs_addr,
    output logic [mips_pkg::REG_ADDR_W-1:0]   rt_addr,
    input  logic [mips_pkg::WORD_W-1:0]       rs_data,
    input  logic [mips_pkg::WORD_W-1:0]       rt_data,
    output logic                              wr_en,
    output logic [mips_pkg::REG_ADDR_W-1:0]   wr_addr,
    output logic [mips_pkg::WORD_W-1:0]       wr_data
);

    localparam int unsigned EXT_W = mips_pkg::WORD_W - mips_pkg::IMM_W;

    mips_pkg::seq_state_e          state;
    logic [mips_pkg::WORD_W-1:0]   pc;
    logic [mips_pkg::WORD_W-1:0]   ir;
    logic [mips_pkg::WORD_W-1:0]   branch_target;
    logic                          branch_pending;
    logic                          halt_pending;

    logic [5:0]                    opcode;
    logic [5:0]                    funct;
    logic [mips_pkg::REG_ADDR_W-1:0] rd_field;

    assign opcode   = ir[31:26];
    assign funct    = ir[5:0];
    assign rd_field = ir[15:11];
    assign rs_addr  = ir[25:21];
    assign rt_addr  = ir[20:16];

    // the address register only changes in ST_EXEC, so it is stable for the whole read
    assign address = pc;

    always_comb begin
        dec.op   = mips_pkg::OP_NOP;
        dec.dest = '0;
        case (opcode)
            6'h00: begin
                // the SPECIAL group is selected by funct
                dec.dest = rd_field;
                case (funct)
                    6'h08: dec.op = mips_pkg::OP_JR;
                    6'h21: dec.op = mips_pkg::OP_ADDU;
                    6'h23: dec.op = mips_pkg::OP_SUBU;
                    6'h24: dec.op = mips_pkg::OP_AND;
                    6'h25: dec.op = mips_pkg::OP_OR;
                    default: dec.op = mips_pkg::OP_NOP;
                endcase
            end
            6'h01: begin
                // in the REGIMM group the rt field picks the condition
                case (rt_addr)
                    5'h00: dec.op = mips_pkg::OP_BLTZ;
                    5'h01: dec.op = mips_pkg::OP_BGEZ;
                    default: dec.op = mips_pkg::OP_NOP;
                endcase
            end
            6'h04: dec.op = mips_pkg::OP_BEQ;
            6'h05: dec.op = mips_pkg::OP_BNE;
            6'h09: begin
                dec.op   = mips_pkg::OP_ADDIU;
                dec.dest = rt_addr;
            end
            6'h0d: begin
                dec.op   = mips_pkg::OP_ORI;
                dec.dest = rt_addr;
            end
            default: dec.op = mips_pkg::OP_NOP;
        endcase
    end

    assign dec.rs_val      = rs_data;
    assign dec.rt_val      = rt_data;
    assign dec.imm_sext    = {{EXT_W{ir[mips_pkg::IMM_W-1]}}, ir[mips_pkg::IMM_W-1:0]};
    assign dec.pc_next_seq = pc + 32'd4;

    // register write happens at the single ST_EXEC edge
    assign wr_en   = (state == mips_pkg::ST_EXEC) && dec.alu_we;
    assign wr_addr = dec.dest;
    assign wr_data = dec.alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= mips_pkg::ST_FETCH;
            pc             <= RESET_VECTOR;
            read           <= 1'b0;
            active         <= 1'b0;
            branch_pending <= 1'b0;
            halt_pending   <= 1'b0;
        end else begin
            case (state)
                mips_pkg::ST_FETCH: begin
                    active <= 1'b1;
                    if (read && !waitrequest) begin
                        ir    <= readdata;
                        read  <= 1'b0;
                        state <= mips_pkg::ST_EXEC;
                    end else begin
                        // only the first fetch after reset arrives here with read low
                        read <= 1'b1;
                    end
                end
                mips_pkg::ST_EXEC: begin
                    // the stored target takes effect after the delay slot in this cycle
                    pc             <= branch_pending ? branch_target : dec.pc_next_seq;
                    branch_pending <= dec.taken;
                    branch_target  <= dec.target;
                    halt_pending   <= dec.halt_req;
                    if (branch_pending && halt_pending) begin
                        state  <= mips_pkg::ST_HALT;
                        active <= 1'b0;
                        read   <= 1'b0;
                    end else begin
                        state <= mips_pkg::ST_FETCH;
                        read  <= 1'b1;
                    end
                end
                default: begin
                    // ST_HALT is left only through reset
                    read   <= 1'b0;
                    active <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: verif/bltz_cases.txt
# header line: name  step_limit  expected_v0 (hex)  word_count
# then the program words in hex, at most 8 per line, loaded from byte address 4 upward
addiu_ori_chain 12 0000f30f 8
24000055 24020010 8c020000 34420300 2442ffff 3442f000 00000008 00000000
bltz_taken_ref 12 000000a0 8
2408ffff 05000003 24020020 24420001 24420002 24420080 00000008 00000000
bltz_not_taken 12 00001111 9
05000002 24020001 24420010 24090005 05200002 24420100 24421000 00000008
00000000
bgez_both_ways 12 00000034 9
04010002 24020004 24420100 2408fffe 05010002 24420010 24420020 00000008
00000000
beq_bne_both_ways 20 0000003f 16
24080003 24090003 11090002 24020001 24420040 15090002 24420002 24420004
11000002 24420008 24420010 15000002 24420020 24420100 00000008 00000000
bne_loop_count 30 0000000f 6
24080005 00481021 1500fffe 2508ffff 00000008 00000000
alu_reg_ops 16 000000b8 11
240800f0 2409003c 01095021 01095823 01096024 01096825 016a1023 004d1024
004c1021 00000008 00000000
jr_halt_slot 12 00000008 7
24080014 01000008 24020003 24420100 00000008 24420005 24420040

// File: verif/mips_cpu_sva.sv
`timescale 1ns/1ns

module mips_cpu_sva (
    input logic                        clk,
    input logic                        reset,
    input logic                        active,
    input logic                        read,
    input logic                        waitrequest,
    input logic [mips_pkg::WORD_W-1:0] address
);

    // a stalled read keeps its request and its address until waitrequest drops
    read_held_while_stalled: assert property (
        @(posedge clk) disable iff (reset)
        read && waitrequest |=> read && $stable(address)
    ) else $error("read or address changed while waitrequest was high");

    // active is low only before the first fetch and after the halt,
    // so this also keeps read at zero once the core has halted
    no_read_while_inactive: assert property (
        @(posedge clk) disable iff (reset)
        !active |-> !read
    ) else $error("read is high while active is low");

    quiet_in_reset: assert property (
        @(posedge clk) reset |=> !read && !active
    ) else $error("read or active is high after a reset cycle");

endmodule

bind mips_cpu mips_cpu_sva u_sva (
    .clk         (clk),
    .reset       (reset),
    .active      (active),
    .read        (read),
    .waitrequest (waitrequest),
    .address     (address)
);

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

// File: verif/tb_mips_cpu.sv
`timescale 1ns/1ns

module tb_mips_cpu;

    localparam int RESET_CYCLES = 16;
    // programs start at byte address 4, which is word 1
    localparam int LOAD_INDEX   = 1;

    logic                        clk;
    logic                        reset;
    logic                        waitrequest;
    logic                        active;
    logic                        read;
    logic [mips_pkg::WORD_W-1:0] register_v0;
    logic [mips_pkg::WORD_W-1:0] address;
    logic [mips_pkg::WORD_W-1:0] readdata;
    logic [mips_pkg::WORD_W-1:0] mem [256];

    string                       case_name [$];
    int                          case_steps [$];
    logic [mips_pkg::WORD_W-1:0] case_expected [$];
    int                          case_first [$];
    int                          case_count [$];
    logic [mips_pkg::WORD_W-1:0] word_q [$];

    integer      seed = 32'hf535;
    bit          stall_en;
    bit          in_read;
    int unsigned stall_left;
    int          cycles;
    int          cycle_limit;
    int          pass_count;
    int          fail_count;

    tb_clock_gen u_clk_gen (.clk (clk));

    mips_cpu u_dut (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .read        (read),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    // the model covers 1 KB, reads above it return zero
    assign readdata = (address[31:10] == '0) ? mem[address[9:2]] : '0;

    // each read is held off for a random 0 to 3 cycles when stalls are on
    always @(negedge clk) begin
        if (read !== 1'b1) begin
            in_read     = 1'b0;
            waitrequest = 1'b0;
        end else if (!in_read) begin
            in_read     = 1'b1;
            stall_left  = stall_en ? $unsigned($random(seed)) % 4 : 0;
            waitrequest = (stall_left != 0);
        end else begin
            if (stall_left != 0) begin
                stall_left = stall_left - 1;
            end
            waitrequest = (stall_left != 0);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the core never halted", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input logic [mips_pkg::WORD_W-1:0] expected,
                              input logic [mips_pkg::WORD_W-1:0] actual);
        if (actual === expected) begin
            pass_count++;
            $display("PASS %s v0 %h", name, actual);
        end else begin
            fail_count++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic load_cases();
        int                          fd;
        int                          n;
        int                          k;
        int                          steps;
        int                          count;
        int                          words_left;
        string                       line;
        string                       name;
        logic [mips_pkg::WORD_W-1:0] expected;
        logic [mips_pkg::WORD_W-1:0] w [8];
        words_left = 0;
        fd = $fopen("verif/bltz_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the cases file verif/bltz_cases.txt");
            fail_count++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            if (words_left == 0) begin
                n = $sscanf(line, "%s %d %h %d", name, steps, expected, count);
                if (n != 4) begin
                    $display("malformed case header in the cases file");
                    fail_count++;
                end else begin
                    case_name.push_back(name);
                    case_steps.push_back(steps);
                    case_expected.push_back(expected);
                    case_first.push_back(word_q.size());
                    case_count.push_back(count);
                    words_left = count;
                end
            end else begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                            w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
                for (k = 0; k < n; k++) begin
                    word_q.push_back(w[k[2:0]]);
                end
                words_left -= n;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_case(input int idx, input bit stalls);
        string name;
        int    a;
        int    b;
        name = case_name[idx];
        if (stalls) begin
            name = {name, "_stall"};
        end
        @(negedge clk);
        reset    = 1'b1;
        stall_en = stalls;
        for (a = 0; a < 256; a++) begin
            mem[a[7:0]] = '0;
        end
        for (a = 0; a < case_count[idx]; a++) begin
            b = a + LOAD_INDEX;
            mem[b[7:0]] = word_q[case_first[idx] + a];
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        // active rises with the first fetch and falls when the halt takes effect
        while (active !== 1'b1) @(negedge clk);
        while (active !== 1'b0) @(negedge clk);
        check_word(name, case_expected[idx], register_v0);
    endtask

    initial begin
        reset       = 1'b1;
        waitrequest = 1'b0;
        stall_en    = 1'b0;
        in_read     = 1'b0;
        stall_left  = 0;
        cycles      = 0;
        cycle_limit = 0;
        pass_count  = 0;
        fail_count  = 0;
        load_cases();
        if (case_name.size() == 0) begin
            $display("no test cases were loaded");
            fail_count++;
        end
        // every case runs once without and once with random stalls
        foreach (case_name[i]) begin
            cycle_limit += 2 * (case_steps[i] * 6 + RESET_CYCLES);
        end
        foreach (case_name[i]) begin
            run_case(i, 1'b0);
            run_case(i, 1'b1);
        end
        $display("%0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
